// File: design/frontEndPkg.sv
// package with front end widths, queue sizes, opcode values, packet typedefs and the cti enum.
package frontEndPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // machine widths and queue sizes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // fetch hands over up to eight words per bundle and dispatch takes four at a time.
  localparam int FETCH_WIDTH    = 8;
  localparam int DISPATCH_WIDTH = 4;

  // the instruction buffer is a 32 entry circular queue with 5 bit pointers.
  localparam int INST_QUEUE     = 32;
  localparam int INST_QUEUE_LOG = 5;

  // fetch is held off while more than this many entries are occupied.
  // the margin is one full bundle, so an accepted bundle always fits.
  localparam int STALL_LIMIT    = INST_QUEUE - FETCH_WIDTH;

  // field widths of a raw instruction word and of a decoded packet.
  localparam int INST_WIDTH   = 32;
  localparam int PC_WIDTH     = 32;
  localparam int OPCODE_WIDTH = 6;
  localparam int REG_WIDTH    = 5;
  localparam int IMM_WIDTH    = 16;
  localparam int CTI_WIDTH    = 2;

  // packet layout from msb down is isBranch, ctiType, opcode, rd, rs1, imm, pc.
  localparam int PACKET_WIDTH   = 1 + CTI_WIDTH + OPCODE_WIDTH + 2 * REG_WIDTH + IMM_WIDTH
                                  + PC_WIDTH;
  localparam int PKT_BRANCH_BIT = PACKET_WIDTH - 1;

  // major opcodes that transfer control.
  localparam logic [OPCODE_WIDTH-1:0] OPC_JUMP      = 6'd2;
  localparam logic [OPCODE_WIDTH-1:0] OPC_CALL      = 6'd3;
  localparam logic [OPCODE_WIDTH-1:0] OPC_BRANCH_LO = 6'd4;
  localparam logic [OPCODE_WIDTH-1:0] OPC_BRANCH_HI = 6'd7;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // vector types.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [INST_WIDTH-1:0]   instWord_t;
  typedef logic [PC_WIDTH-1:0]     pc_t;
  typedef logic [OPCODE_WIDTH-1:0] opcode_t;
  typedef logic [REG_WIDTH-1:0]    regIdx_t;
  typedef logic [IMM_WIDTH-1:0]    imm_t;

  // control transfer class of one instruction.
  typedef enum logic [CTI_WIDTH-1:0] {
    ctiNone       = 2'd0,
    ctiJump       = 2'd1,
    ctiCall       = 2'd2,
    ctiCondBranch = 2'd3
  } ctiType_e;

  typedef logic [PACKET_WIDTH-1:0]                decodedPacket_t;
  typedef logic [FETCH_WIDTH*PACKET_WIDTH-1:0]    decodedBundle_t;
  typedef logic [DISPATCH_WIDTH*PACKET_WIDTH-1:0] dispatchWindow_t;
  typedef logic [FETCH_WIDTH-1:0]                 fetchVector_t;
  typedef logic [FETCH_WIDTH*INST_WIDTH-1:0]      instWordBundle_t;
  typedef logic [3:0]                             slotCount_t;
  typedef logic [INST_QUEUE_LOG-1:0]              queuePtr_t;
  typedef logic [INST_QUEUE_LOG:0]                queueCount_t;
  typedef logic [2:0]                             branchCount_t;

endpackage

// File: design/fetchPreDecoder.sv
// fetch bundle pre-decoder with slot decode, valid slot compaction and the output register.
`timescale 1ns/1ps

module fetchPreDecoder import frontEndPkg::*; (
  input  logic            clk,
  input  logic            arstN_i,
  input  logic            flush_i,
  input  logic            fetchValid_i,
  input  fetchVector_t    fetchVector_i,
  input  instWordBundle_t fetchBundle_i,
  input  pc_t             fetchPc_i,
  input  logic            stallFetch_i,
  output logic            decodeReady_o,
  output decodedBundle_t  decodedBundle_o,
  output slotCount_t      decodedCount_o
);

  // compacted packets and their count, ready to be registered on a strobe.
  decodedBundle_t compactBundle;
  slotCount_t     compactCount;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // slot decode.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // maps a major opcode onto its control transfer class.
  // every opcode outside the jump, call and branch ranges is ordinary.
  function automatic ctiType_e classifyOpcode(input opcode_t opcode);
    ctiType_e cti;
    if (opcode == OPC_JUMP) begin
      cti = ctiJump;
    end else if (opcode == OPC_CALL) begin
      cti = ctiCall;
    end else if ((opcode >= OPC_BRANCH_LO) && (opcode <= OPC_BRANCH_HI)) begin
      cti = ctiCondBranch;
    end else begin
      cti = ctiNone;
    end
    return cti;
  endfunction

  // builds one packet from a raw word and the pc of its slot.
  function automatic decodedPacket_t decodeSlot(input instWord_t word, input pc_t pc);
    opcode_t  opcode;
    ctiType_e cti;
    regIdx_t  rd;
    regIdx_t  rs1;
    imm_t     imm;
    logic     isBranch;
    opcode   = word[31:26];
    rd       = word[25:21];
    rs1      = word[20:16];
    imm      = word[15:0];
    cti      = classifyOpcode(opcode);
    // only conditional branches count toward the branch total at dispatch.
    isBranch = (cti == ctiCondBranch);
    return {isBranch, cti, opcode, rd, rs1, imm, pc};
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compaction of the valid slots.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // valid slots are packed toward slot 0 in their original order.
  // the fill index is both the next free packet position and the final count.
  always_comb begin : compactSlots
    slotCount_t fill;
    fill          = '0;
    compactBundle = '0;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      if (fetchVector_i[k]) begin
        // slot k sits four bytes per slot above the bundle base.
        compactBundle[fill*PACKET_WIDTH +: PACKET_WIDTH] =
          decodeSlot(fetchBundle_i[k*INST_WIDTH +: INST_WIDTH], fetchPc_i + pc_t'(4 * k));
        fill = fill + slotCount_t'(1);
      end
    end
    compactCount = fill;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output register.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a strobe loads a new bundle and raises ready on the same edge.
  // without a strobe the bundle is consumed on any edge where the buffer is not stalled.
  // while the buffer stalls the bundle and ready simply hold.
  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      decodeReady_o  <= 1'b0;
      decodedCount_o <= '0;
    end else if (flush_i) begin
      // a misprediction drops whatever bundle is pending.
      decodeReady_o  <= 1'b0;
      decodedCount_o <= '0;
    end else if (fetchValid_i) begin
      decodeReady_o  <= 1'b1;
      decodedCount_o <= compactCount;
    end else if (!stallFetch_i) begin
      decodeReady_o  <= 1'b0;
    end
  end

  // packet payload follows the strobe only.
  always_ff @(posedge clk) begin
    if (fetchValid_i) begin
      decodedBundle_o <= compactBundle;
    end
  end

endmodule

// File: design/instBufferRam.sv
// instruction buffer storage array with eight write ports and four asynchronous read ports.
`timescale 1ns/1ps

module instBufferRam import frontEndPkg::*; (
  input  logic                                   clk,
  input  fetchVector_t                           writeEnable_i,
  input  logic [FETCH_WIDTH*INST_QUEUE_LOG-1:0]    writeAddr_i,
  input  decodedBundle_t                         writeData_i,
  input  logic [DISPATCH_WIDTH*INST_QUEUE_LOG-1:0] readAddr_i,
  output dispatchWindow_t                        readData_o
);

  // one decoded packet per queue entry.
  decodedPacket_t mem [INST_QUEUE];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write ports.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // all eight ports write on the same edge.
  // the controller hands out consecutive addresses from the tail, so two
  // enabled ports never target the same entry.
  // port k carries packet k of the compacted bundle.
  always_ff @(posedge clk) begin
    for (int w = 0; w < FETCH_WIDTH; w++) begin
      if (writeEnable_i[w]) begin
        mem[writeAddr_i[w*INST_QUEUE_LOG +: INST_QUEUE_LOG]] <=
          writeData_i[w*PACKET_WIDTH +: PACKET_WIDTH];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read ports.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // reads are combinational so the dispatch window follows the head pointer
  // within the same cycle.
  // read port r feeds packet r of the window, oldest instruction in the low bits.
  // an entry written on this edge becomes visible after the edge, which is also
  // when the count that would expose it is updated.
  always_comb begin
    for (int r = 0; r < DISPATCH_WIDTH; r++) begin
      readData_o[r*PACKET_WIDTH +: PACKET_WIDTH] =
        mem[readAddr_i[r*INST_QUEUE_LOG +: INST_QUEUE_LOG]];
    end
  end

endmodule

// File: design/instBuffer.sv
// instruction buffer queue control with pointers, count, fetch stall, readiness and branch count.
`timescale 1ns/1ps

module instBuffer import frontEndPkg::*; (
  input  logic            clk,
  input  logic            arstN_i,
  input  logic            flush_i,
  input  logic            dispatchStall_i,
  input  logic            decodeReady_i,
  input  decodedBundle_t  decodedBundle_i,
  input  slotCount_t      decodedCount_i,
  output logic            stallFetch_o,
  output logic            instBufferReady_o,
  output dispatchWindow_t dispatchWindow_o,
  output branchCount_t    branchCount_o
);

  // head points at the oldest instruction and tail at the first free entry.
  queuePtr_t   headPtr;
  queuePtr_t   tailPtr;

  // number of instructions waiting in the queue.
  queueCount_t instCount;
  queueCount_t countNext;

  // write side of the storage array.
  logic                                   writeGo;
  fetchVector_t                           writeEnable;
  logic [FETCH_WIDTH*INST_QUEUE_LOG-1:0]    writeAddr;

  // read side of the storage array.
  logic                                   dispatchGo;
  logic [DISPATCH_WIDTH*INST_QUEUE_LOG-1:0] readAddr;
  dispatchWindow_t                        readWindow;

  instBufferRam i_instBufferRam (
    .clk           (clk),
    .writeEnable_i (writeEnable),
    .writeAddr_i   (writeAddr),
    .writeData_i   (decodedBundle_i),
    .readAddr_i    (readAddr),
    .readData_o    (readWindow)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // status levels.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // fetch stalls once fewer than a full bundle of entries remain free.
  assign stallFetch_o      = (instCount > queueCount_t'(STALL_LIMIT));

  // a window is only offered whole, never partially.
  assign instBufferReady_o = (instCount >= queueCount_t'(DISPATCH_WIDTH));

  // a pending bundle is accepted on any edge where fetch is not stalled.
  assign writeGo    = decodeReady_i & ~stallFetch_o;
  assign dispatchGo = instBufferReady_o & ~dispatchStall_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address generation.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // packets arrive compacted, so the first decodedCount_i ports are enabled.
  // pointer arithmetic wraps naturally at the queue size.
  always_comb begin
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      writeEnable[k] = writeGo && (slotCount_t'(k) < decodedCount_i);
      writeAddr[k*INST_QUEUE_LOG +: INST_QUEUE_LOG] = tailPtr + queuePtr_t'(k);
    end
  end

  // the window is always read at the head.
  always_comb begin
    for (int r = 0; r < DISPATCH_WIDTH; r++) begin
      readAddr[r*INST_QUEUE_LOG +: INST_QUEUE_LOG] = headPtr + queuePtr_t'(r);
    end
  end

  assign dispatchWindow_o = readWindow;

  // counts the conditional branches among the four window packets.
  // the count reads as zero while no whole window is offered.
  always_comb begin
    branchCount_o = '0;
    if (instBufferReady_o) begin
      for (int r = 0; r < DISPATCH_WIDTH; r++) begin
        branchCount_o = branchCount_o
                        + branchCount_t'(readWindow[r*PACKET_WIDTH + PKT_BRANCH_BIT]);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointer and count update.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a write and a dispatch may both land on one edge.
  // the count cannot overflow since writes stop above the stall limit.
  always_comb begin
    countNext = instCount;
    if (writeGo) begin
      countNext = countNext + queueCount_t'(decodedCount_i);
    end
    if (dispatchGo) begin
      countNext = countNext - queueCount_t'(DISPATCH_WIDTH);
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0;
    end else if (flush_i) begin
      // a misprediction empties the queue in one edge.
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0;
    end else begin
      if (writeGo) begin
        tailPtr <= tailPtr + queuePtr_t'(decodedCount_i);
      end
      if (dispatchGo) begin
        headPtr <= headPtr + queuePtr_t'(DISPATCH_WIDTH);
      end
      instCount <= countNext;
    end
  end

endmodule

// File: design/decodeBufferTop.sv
// decode to dispatch top level joining the fetch pre-decoder and the instruction buffer.
`timescale 1ns/1ps

module decodeBufferTop import frontEndPkg::*; (
  input  logic            clk,
  input  logic            arstN_i,
  input  logic            flush_i,
  input  logic            fetchValid_i,
  input  fetchVector_t    fetchVector_i,
  input  instWordBundle_t fetchBundle_i,
  input  pc_t             fetchPc_i,
  input  logic            dispatchStall_i,
  output logic            stallFetch_o,
  output logic            instBufferReady_o,
  output dispatchWindow_t dispatchWindow_o,
  output branchCount_t    branchCount_o
);

  // handshake between the pre-decoder and the buffer.
  logic           decodeReady;
  decodedBundle_t decodedBundle;
  slotCount_t     decodedCount;
  logic           stallFetch;

  // the buffer stall holds the pending bundle and also goes out to fetch.
  assign stallFetch_o = stallFetch;

  fetchPreDecoder i_fetchPreDecoder (
    .clk             (clk),
    .arstN_i         (arstN_i),
    .flush_i         (flush_i),
    .fetchValid_i    (fetchValid_i),
    .fetchVector_i   (fetchVector_i),
    .fetchBundle_i   (fetchBundle_i),
    .fetchPc_i       (fetchPc_i),
    .stallFetch_i    (stallFetch),
    .decodeReady_o   (decodeReady),
    .decodedBundle_o (decodedBundle),
    .decodedCount_o  (decodedCount)
  );

  instBuffer i_instBuffer (
    .clk               (clk),
    .arstN_i           (arstN_i),
    .flush_i           (flush_i),
    .dispatchStall_i   (dispatchStall_i),
    .decodeReady_i     (decodeReady),
    .decodedBundle_i   (decodedBundle),
    .decodedCount_i    (decodedCount),
    .stallFetch_o      (stallFetch),
    .instBufferReady_o (instBufferReady_o),
    .dispatchWindow_o  (dispatchWindow_o),
    .branchCount_o     (branchCount_o)
  );

endmodule

// File: bench/clockGen.sv
// testbench clock and active low reset generator.
`timescale 1ns/1ps

module clockGen (
  output logic clk_o,
  output logic arstN_o
);

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;

  // free running clock with a 40 ns period.
  initial begin
    clk_o = 1'b0;
    forever #(CLK_PERIOD / 2) clk_o = ~clk_o;
  end

  // reset is held for ten rising edges and released on a falling edge.
  initial begin
    arstN_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arstN_o = 1'b1;
  end

endmodule

// File: bench/decodeBufferTb.sv
// testbench with the reference queue model, directed tests, compare tasks and the watchdog.
`timescale 1ns/1ps

module decodeBufferTb import frontEndPkg::*; ();

  localparam int CLK_PERIOD    = 40;
  localparam int RANDOM_CYCLES = 300;
  localparam int DRAIN_LIMIT   = 100;
  // reset, the five directed tests with their drains, random traffic and a margin.
  localparam int CYCLE_BUDGET  = 12 + 110 + 120 + 120 + 110 + RANDOM_CYCLES + DRAIN_LIMIT + 200;

  logic            clk;
  logic            arstN;
  logic            flush;
  logic            fetchValid;
  fetchVector_t    fetchVector;
  instWordBundle_t fetchBundle;
  pc_t             fetchPc;
  logic            dispatchStall;
  logic            stallFetch;
  logic            instBufferReady;
  dispatchWindow_t dispatchWindow;
  branchCount_t    branchCount;

  // reference model, with the queued packets and the bundle held by the pre-decoder.
  decodedPacket_t modelQ[$];
  decodedPacket_t pendQ[$];
  logic           pendValid;
  int             errorCount;
  int             checkCount;

  clockGen i_clockGen (.clk_o(clk), .arstN_o(arstN));

  decodeBufferTop i_decodeBufferTop (
    .clk               (clk),
    .arstN_i           (arstN),
    .flush_i           (flush),
    .fetchValid_i      (fetchValid),
    .fetchVector_i     (fetchVector),
    .fetchBundle_i     (fetchBundle),
    .fetchPc_i         (fetchPc),
    .dispatchStall_i   (dispatchStall),
    .stallFetch_o      (stallFetch),
    .instBufferReady_o (instBufferReady),
    .dispatchWindow_o  (dispatchWindow),
    .branchCount_o     (branchCount)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // expected decode and compare tasks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // opcode 2 jumps, 3 calls, 4 to 7 branch on a condition, everything else is ordinary.
  function automatic decodedPacket_t expectPacket(input instWord_t word, input pc_t pc);
    ctiType_e cti;
    logic     isBranch;
    case (word[31:26])
      6'd2: cti = ctiJump;
      6'd3: cti = ctiCall;
      6'd4, 6'd5, 6'd6, 6'd7: cti = ctiCondBranch;
      default: cti = ctiNone;
    endcase
    isBranch = (cti == ctiCondBranch);
    return {isBranch, cti, word[31:26], word[25:21], word[20:16], word[15:0], pc};
  endfunction

  // eight words with opcodes 0 to 9, so every control transfer class shows up.
  function automatic instWordBundle_t randomWords();
    instWordBundle_t words;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      words[k*INST_WIDTH +: INST_WIDTH] = {opcode_t'($urandom % 10), 26'($urandom)};
    end
    return words;
  endfunction

  task automatic checkPacket(input string testName, input decodedPacket_t expected,
                             input decodedPacket_t actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED %s: packet expected %h actual %h", testName, expected, actual);
    end
  endtask

  task automatic checkBranchCount(input string testName, input branchCount_t expected,
                                  input branchCount_t actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED %s: branch count expected %0d actual %0d", testName, expected, actual);
    end
  endtask

  task automatic checkFlag(input string testName, input string flagName,
                           input logic expected, input logic actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED %s: %s expected %b actual %b", testName, flagName, expected, actual);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // cycle stepping and the model.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // called on a falling edge once the inputs are driven.
  // outputs are compared here, the model then takes the coming rising edge, and the task
  // returns on the next falling edge with the one cycle pulses dropped.
  task automatic tick(input string testName);
    logic modelReady;
    logic modelStall;
    int   branches;
    modelReady = (modelQ.size() >= DISPATCH_WIDTH);
    modelStall = (modelQ.size() > STALL_LIMIT);
    checkFlag(testName, "ready", modelReady, instBufferReady);
    checkFlag(testName, "stall", modelStall, stallFetch);
    if (flush) begin
      modelQ.delete();
      pendValid = 1'b0;
    end else begin
      // a ready window with no dispatch stall leaves the queue whole, oldest packet first.
      if (modelReady && !dispatchStall) begin
        branches = 0;
        for (int r = 0; r < DISPATCH_WIDTH; r++) begin
          checkPacket(testName, modelQ[0], dispatchWindow[r*PACKET_WIDTH +: PACKET_WIDTH]);
          branches += int'(modelQ[0][PKT_BRANCH_BIT]);
          void'(modelQ.pop_front());
        end
        checkBranchCount(testName, branchCount_t'(branches), branchCount);
      end
      // the pending bundle enters the queue unless fetch is stalled.
      if (pendValid && !modelStall) begin
        foreach (pendQ[i]) begin
          modelQ.push_back(pendQ[i]);
        end
        pendValid = 1'b0;
      end
      // a strobe is compacted in slot order, slot k sitting at pc plus four times k.
      if (fetchValid) begin
        pendQ.delete();
        for (int k = 0; k < FETCH_WIDTH; k++) begin
          if (fetchVector[k]) begin
            pendQ.push_back(expectPacket(fetchBundle[k*INST_WIDTH +: INST_WIDTH],
                                         fetchPc + pc_t'(4 * k)));
          end
        end
        pendValid = 1'b1;
      end
    end
    @(negedge clk);
    fetchValid = 1'b0;
    flush      = 1'b0;
  endtask

  // fetch waits out the stall before it strobes.
  task automatic sendBundle(input string testName, input fetchVector_t vector,
                            input instWordBundle_t words, input pc_t pc);
    while (stallFetch) begin
      tick(testName);
    end
    fetchValid  = 1'b1;
    fetchVector = vector;
    fetchBundle = words;
    fetchPc     = pc;
    tick(testName);
  endtask

  // releases dispatch and runs until no whole window and no pending bundle remain.
  task automatic drain(input string testName);
    int budget;
    budget        = DRAIN_LIMIT;
    dispatchStall = 1'b0;
    while ((pendValid || modelQ.size() >= DISPATCH_WIDTH) && budget > 0) begin
      tick(testName);
      budget--;
    end
    if (budget == 0) begin
      errorCount++;
      $display("%s: the queue did not drain within %0d cycles", testName, DRAIN_LIMIT);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic resetState();
    checkFlag("resetState", "ready", 1'b0, instBufferReady);
    checkFlag("resetState", "stall", 1'b0, stallFetch);
    checkBranchCount("resetState", 3'd0, branchCount);
    tick("resetState");
  endtask

  task automatic fullBundle();
    instWordBundle_t words;
    opcode_t         ops [FETCH_WIDTH];
    // window 0 holds one conditional branch and window 1 holds three.
    ops = '{6'd2, 6'd4, 6'd0, 6'd3, 6'd7, 6'd5, 6'd12, 6'd6};
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      words[k*INST_WIDTH +: INST_WIDTH] = {ops[k], regIdx_t'(k), regIdx_t'(31 - k),
                                           imm_t'(16'hA000 + k)};
    end
    sendBundle("fullBundle", 8'hFF, words, 32'h0000_1000);
    // the strobe edge has passed and the queue takes the bundle on the next one.
    checkFlag("fullBundle", "ready", 1'b0, instBufferReady);
    tick("fullBundle");
    checkFlag("fullBundle", "ready", 1'b1, instBufferReady);
    checkBranchCount("fullBundle", 3'd1, branchCount);
    tick("fullBundle");
    checkBranchCount("fullBundle", 3'd3, branchCount);
    drain("fullBundle");
  endtask

  task automatic sparseBundles();
    fetchVector_t vectors [5];
    // three, one, two, three and three valid slots, twelve in all.
    vectors = '{8'b1000_0101, 8'b0001_0000, 8'b0110_0000, 8'b0100_1001, 8'b0000_1110};
    for (int b = 0; b < 5; b++) begin
      sendBundle("sparseBundles", vectors[b], randomWords(), pc_t'(32'h2000 + 32 * b));
      if (b == 0) begin
        // three queued packets are not yet a window.
        tick("sparseBundles");
        checkFlag("sparseBundles", "ready", 1'b0, instBufferReady);
      end
    end
    drain("sparseBundles");
  endtask

  task automatic stallFill();
    int bundles;
    bundles       = 0;
    dispatchStall = 1'b1;
    while (!stallFetch && bundles < 8) begin
      sendBundle("stallFill", 8'hFF, randomWords(), pc_t'(32'h3000 + 32 * bundles));
      bundles++;
    end
    checkFlag("stallFill", "stall", 1'b1, stallFetch);
    if (modelQ.size() <= STALL_LIMIT) begin
      errorCount++;
      $display("stallFill: fetch stalled with only %0d instructions queued", modelQ.size());
    end
    // the last bundle waits in the pre-decoder while the queue is held.
    repeat (3) tick("stallFill");
    drain("stallFill");
  endtask

  task automatic flushRecovery();
    dispatchStall = 1'b1;
    for (int b = 0; b < 4; b++) begin
      sendBundle("flushRecovery", 8'hFF, randomWords(), pc_t'(32'h4000 + 32 * b));
    end
    sendBundle("flushRecovery", 8'h3C, randomWords(), 32'h4080);
    // the queue sits past the stall limit and one more bundle waits in the pre-decoder.
    checkFlag("flushRecovery", "ready", 1'b1, instBufferReady);
    checkFlag("flushRecovery", "stall", 1'b1, stallFetch);
    flush = 1'b1;
    tick("flushRecovery");
    checkFlag("flushRecovery", "ready", 1'b0, instBufferReady);
    checkFlag("flushRecovery", "stall", 1'b0, stallFetch);
    dispatchStall = 1'b0;
    sendBundle("flushRecovery", 8'h0F, randomWords(), 32'h5000);
    drain("flushRecovery");
  endtask

  task automatic randomTraffic();
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      // dispatch runs slower than fetch on average, so the stall threshold gets reached.
      dispatchStall = (($urandom % 3) == 0);
      if (!stallFetch && (($urandom % 4) != 0)) begin
        fetchValid  = 1'b1;
        fetchVector = fetchVector_t'($urandom);
        fetchBundle = randomWords();
        fetchPc     = pc_t'($urandom) & 32'hFFFF_FFFC;
      end
      tick("randomTraffic");
    end
    drain("randomTraffic");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence and watchdog.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    void'($urandom(55));
    errorCount    = 0;
    checkCount    = 0;
    pendValid     = 1'b0;
    flush         = 1'b0;
    fetchValid    = 1'b0;
    fetchVector   = '0;
    fetchBundle   = '0;
    fetchPc       = '0;
    dispatchStall = 1'b0;
    // reset is released on a falling edge, which is where stimulus starts.
    @(posedge arstN);
    resetState();
    fullBundle();
    sparseBundles();
    stallFill();
    flushRecovery();
    randomTraffic();
    $display("summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(CYCLE_BUDGET * CLK_PERIOD);
    $display("timeout: the tests did not complete within %0d cycles", CYCLE_BUDGET);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: decodeBufferTop.f
design/frontEndPkg.sv
design/fetchPreDecoder.sv
design/instBufferRam.sv
design/instBuffer.sv
design/decodeBufferTop.sv
bench/clockGen.sv
bench/decodeBufferTb.sv

// File: Makefile
# Verilator build and run of the decode to dispatch testbench.
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := decodeBufferTb
FILELIST  := decodeBufferTop.f
OBJDIR    := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# the run passes only if the log holds the pass message.
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message missing from $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
